//--- build.f
rv_pkg.sv
rv_imm_gen.sv
rv_alu.sv
rv_regfile.sv
rv_control.sv
rv_core.sv
rv_core_assertions.sv
rv_core_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the rv_core testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_core_tb -f build.f \
    && ./obj_dir/Vrv_core_tb | tee /dev/stderr | grep -q "^Result: PASSED$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0

//--- rv_alu.sv
`default_nettype none

module rv_alu
    import rv_pkg::*;
(
    input  alu_op_e alu_op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    zero,
    output logic    less,
    output logic    less_u
);

    logic [4:0] shamt;    // Shift amount

    assign shamt  = b[4:0];
    assign less   = $signed(a) < $signed(b);   // Signed compare
    assign less_u = a < b;
    assign zero   = (result == '0);             // Equal operands after SUB

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, less};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, less_u};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);   // Keeps sign
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_control.sv
`default_nettype none

module rv_control
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  opcode_e   opcode,
    input  logic [2:0] funct3,
    input  logic      funct7_5,     // Instruction bit 30
    input  logic      alu_zero,     // Flags registered in EXECUTE
    input  logic      alu_less,
    input  logic      alu_less_u,
    output state_e    state,
    output src_a_e    src_a,
    output src_b_e    src_b,
    output alu_op_e   alu_op,
    output imm_kind_e imm_kind,
    output wb_sel_e   wb_sel,
    output logic      rf_we,
    output logic      take_target,
    output logic      retire
);

    logic branch_taken;   // Condition of the current branch
    logic writes_rd;      // Opcode has a destination register

    // ALU op from funct3, alt selects SUB or SRA
    function automatic alu_op_e funct3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Four cycles per instruction, no stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
        end else begin
            case (state)
                S_FETCH:     state <= S_DECODE;
                S_DECODE:    state <= S_EXECUTE;
                S_EXECUTE:   state <= S_WRITEBACK;
                default:     state <= S_FETCH;      // Back after writeback
            endcase
        end
    end

    // Immediate format depends on the opcode alone
    always_comb begin
        case (opcode)
            OP_LUI:    imm_kind = IMM_U;
            OP_BRANCH: imm_kind = IMM_B;
            OP_JAL:    imm_kind = IMM_J;
            default:   imm_kind = IMM_I;
        endcase
    end

    // Writeback source
    always_comb begin
        wb_sel = WB_ALU;   // JAL gets PC + 4 from the ALU
        if (opcode == OP_LUI) begin
            wb_sel = WB_IMM;
        end else if ((opcode == OP_REG || opcode == OP_IMM) && funct3[2:1] == 2'b01) begin
            wb_sel = WB_FLAG;   // SLT, SLTU and immediate forms
        end
    end

    // Operand selects and ALU op
    always_comb begin
        src_a  = SRC_A_RS1;
        src_b  = SRC_B_RS2;
        alu_op = ALU_ADD;
        if (state == S_DECODE) begin
            // PC + 4 for the next-PC register
            src_a = SRC_A_PC;
            src_b = SRC_B_FOUR;
        end else begin
            case (opcode)
                OP_REG: alu_op = funct3_op(funct3, funct7_5);
                OP_IMM: begin
                    src_b  = SRC_B_IMM;
                    // No SUBI, bit 30 only matters for SRAI
                    alu_op = funct3_op(funct3, funct7_5 && funct3 == 3'b101);
                end
                OP_LUI: src_b = SRC_B_IMM;        // Result unused
                OP_BRANCH: alu_op = ALU_SUB;      // rs1 - rs2 sets the flags
                OP_JAL: begin
                    src_a = SRC_A_PC;             // Link address
                    src_b = SRC_B_FOUR;
                end
                default: ;                        // Unknown opcode, no-op
            endcase
        end
    end

    // Branch condition from registered flags
    always_comb begin
        case (funct3)
            BEQ:     branch_taken = alu_zero;
            BNE:     branch_taken = !alu_zero;
            BLT:     branch_taken = alu_less;
            BGE:     branch_taken = !alu_less;
            BLTU:    branch_taken = alu_less_u;
            BGEU:    branch_taken = !alu_less_u;
            default: branch_taken = 1'b0;
        endcase
    end

    assign writes_rd = opcode inside {OP_REG, OP_IMM, OP_LUI, OP_JAL};

    assign retire      = (state == S_WRITEBACK);   // Also loads the PC
    assign rf_we       = retire && writes_rd;
    assign take_target = retire && (opcode == OP_JAL ||
                                    (opcode == OP_BRANCH && branch_taken));

endmodule

`default_nettype wire

//--- rv_core.sv
`default_nettype none

module rv_core
    import rv_pkg::*;
#(
    parameter word_t RESET_PC = '0,
    parameter int    NUM_REGS = 32
) (
    input  logic     clk,
    input  logic     reset,
    output word_t    imem_addr,
    input  word_t    imem_data,
    output logic     retire,
    output word_t    retire_pc,
    output logic     rd_we,
    output reg_idx_t rd_addr,
    output word_t    rd_data
);

    word_t pc, ir;              // Program counter, instruction register
    word_t pc_plus4_q;          // Next sequential PC from DECODE
    word_t target_q;            // Branch or jump target
    word_t alu_q;               // EXECUTE result
    logic  zero_q, less_q, less_u_q;

    state_e    state;
    src_a_e    src_a;
    src_b_e    src_b;
    alu_op_e   alu_op;
    imm_kind_e imm_kind;
    wb_sel_e   wb_sel;
    logic      rf_we, take_target;

    word_t imm, rs1_data, rs2_data;
    word_t alu_a, alu_b, alu_result;
    logic  alu_zero, alu_less, alu_less_u;

    rv_control u_control (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode_e'(ir[6:0])),
        .funct3      (ir[14:12]),
        .funct7_5    (ir[30]),
        .alu_zero    (zero_q),
        .alu_less    (less_q),
        .alu_less_u  (less_u_q),
        .state       (state),
        .src_a       (src_a),
        .src_b       (src_b),
        .alu_op      (alu_op),
        .imm_kind    (imm_kind),
        .wb_sel      (wb_sel),
        .rf_we       (rf_we),
        .take_target (take_target),
        .retire      (retire)
    );

    rv_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .clk      (clk),
        .rs1_addr (ir[19:15]),
        .rs2_addr (ir[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    rv_imm_gen u_imm_gen (.instr(ir), .imm_kind(imm_kind), .imm(imm));

    rv_alu u_alu (
        .alu_op (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero),
        .less   (alu_less),
        .less_u (alu_less_u)
    );

    assign alu_a = (src_a == SRC_A_PC) ? pc : rs1_data;

    always_comb begin
        case (src_b)
            SRC_B_IMM:  alu_b = imm;
            SRC_B_FOUR: alu_b = 32'd4;
            default:    alu_b = rs2_data;
        endcase
    end

    // Writeback data, flag chosen by funct3 bit 0 (SLTU)
    always_comb begin
        case (wb_sel)
            WB_IMM:  rd_data = imm;
            WB_FLAG: rd_data = {{(XLEN-1){1'b0}}, ir[12] ? less_u_q : less_q};
            default: rd_data = alu_q;
        endcase
    end

    // PC changes only at the end of WRITEBACK
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (retire) begin
            pc <= take_target ? target_q : pc_plus4_q;
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_FETCH:  ir <= imem_data;      // Combinational memory answer
            S_DECODE: begin
                pc_plus4_q <= alu_result;
                target_q   <= pc + imm;     // Separate target adder
            end
            S_EXECUTE: begin
                alu_q    <= alu_result;
                zero_q   <= alu_zero;
                less_q   <= alu_less;
                less_u_q <= alu_less_u;
            end
            default: ;
        endcase
    end

    assign imem_addr = pc;
    assign retire_pc = pc;          // Still this instruction's PC
    assign rd_we     = rf_we;
    assign rd_addr   = ir[11:7];

endmodule

`default_nettype wire

//--- rv_core_assertions.sv
`default_nettype none

module rv_core_assertions
    import rv_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  retire,
    input logic  rd_we,
    input word_t imem_addr
);

    timeunit 1ns;
    timeprecision 1ps;

    // Strobe lasts one cycle
    retire_single: assert property (@(posedge clk) disable iff (reset) retire |=> !retire)
        else $error("retire high in two consecutive cycles");

    // Quiet until the next WRITEBACK
    retire_gap_2: assert property (@(posedge clk) disable iff (reset) retire |-> ##2 !retire)
        else $error("retire two cycles after a retire");
    retire_gap_3: assert property (@(posedge clk) disable iff (reset) retire |-> ##3 !retire)
        else $error("retire three cycles after a retire");
    retire_period: assert property (@(posedge clk) disable iff (reset) retire |-> ##4 retire)
        else $error("no retire four cycles after a retire");

    rd_we_in_writeback: assert property (@(posedge clk) disable iff (reset) rd_we |-> retire)
        else $error("register write outside a retire");

    fetch_aligned: assert property (@(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00)
        else $error("instruction address not word aligned");   // Offsets are word multiples

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .retire    (retire),
    .rd_we     (rd_we),
    .imem_addr (imem_addr)
);

`default_nettype wire

//--- rv_core_tb.sv
`default_nettype none

module rv_core_tb
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    NUM_RETIRES = 400;                    // Length of the run
    localparam int    CYCLE_LIMIT = 8 * NUM_RETIRES + 100;  // Twice the 4-cycle pace plus margin
    localparam word_t START_PC    = 32'h0;                  // uut keeps the default RESET_PC

    logic     clk = 1'b0;
    logic     reset;
    word_t    imem_addr, imem_data;
    logic     retire, rd_we;
    word_t    retire_pc, rd_data;
    reg_idx_t rd_addr;

    word_t      prog [64];           // Program image, 64 words
    word_t      model_regs [32];     // Architectural state of the model
    word_t      model_pc;
    logic [2:0] br_f3 [6];
    int seed = 32'h290e;
    int fill = 0;                    // Next free program word
    int cycles = 0, retires = 0, since_reset = 0;
    int checked = 0, errors = 0;

    always #50 clk = ~clk;           // 100 ns period

    assign imem_data = prog[imem_addr[7:2]];   // Word index wraps every 64 words

    rv_core uut (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire),
        .retire_pc (retire_pc),
        .rd_we     (rd_we),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // Instruction encoders
    function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};   // LUI
    endfunction

    // Offset in bytes, bit 0 dropped
    function automatic word_t b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                     input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};   // JAL
    endfunction

    task automatic place(input word_t instr);
        prog[6'(fill)] = instr;
        fill++;
    endtask

    // Random instruction of the kept set, registers x0 to x15 only
    function automatic word_t random_instr();
        int         kind;
        int         off;
        logic [4:0] rd, rs1, rs2;
        logic [2:0] f3;
        logic       alt;
        logic [11:0] imm;
        kind = $random(seed) & 7;
        off  = ($random(seed) & 31) - 16;   // Words, -16 to 15
        if (off == 0) begin
            off = 16;                        // No self loops
        end
        rd  = {1'b0, 4'($random(seed))};
        rs1 = {1'b0, 4'($random(seed))};
        rs2 = {1'b0, 4'($random(seed))};
        f3  = 3'($random(seed));
        alt = 1'($random(seed));
        imm = 12'($random(seed));
        case (kind)
            0, 1, 2: return r_type((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                                   rs2, rs1, f3, rd);
            3, 4: begin
                if (f3 == 3'b001) begin
                    imm = {7'h00, imm[4:0]};                      // SLLI
                end else if (f3 == 3'b101) begin
                    imm = {alt ? 7'h20 : 7'h00, imm[4:0]};        // SRLI or SRAI
                end
                return i_type(imm, rs1, f3, rd);
            end
            5: return u_type(20'($random(seed)), rd);
            6: begin
                if (f3[2:1] == 2'b01) begin
                    f3 = {2'b00, f3[0]};   // No branch in 010 and 011
                end
                return b_type(f3, rs1, rs2, 13'(off * 4));
            end
            default: return j_type(rd, 21'(off * 4));
        endcase
    endfunction

    // Integer op by funct3, alt picks SUB or SRA
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? (a - b) : (a + b);
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, ($signed(a) < $signed(b))};
            3'b011:  return {31'b0, (a < b)};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // One instruction of the reference model
    function automatic void iss_step(output logic exp_we, output reg_idx_t exp_rd,
                                     output word_t exp_data);
        word_t      instr, a, b, imm_i, imm_b, imm_j, next_pc;
        logic [2:0] f3;
        logic       taken;
        instr    = prog[model_pc[7:2]];
        f3       = instr[14:12];
        a        = model_regs[instr[19:15]];
        b        = model_regs[instr[24:20]];
        imm_i    = {{20{instr[31]}}, instr[31:20]};
        imm_b    = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        exp_we   = 1'b0;
        exp_rd   = instr[11:7];
        exp_data = '0;
        next_pc  = model_pc + 32'd4;
        taken    = 1'b0;
        case (instr[6:0])
            7'b0110011: begin   // Register-register
                exp_we   = 1'b1;
                exp_data = alu_ref(f3, instr[30], a, b);
            end
            7'b0010011: begin   // Immediate, bit 30 only for SRAI
                exp_we   = 1'b1;
                exp_data = alu_ref(f3, instr[30] && f3 == 3'b101, a, imm_i);
            end
            7'b0110111: begin
                exp_we   = 1'b1;
                exp_data = {instr[31:12], 12'b0};
            end
            7'b1101111: begin
                exp_we   = 1'b1;
                exp_data = model_pc + 32'd4;   // Link
                next_pc  = model_pc + imm_j;
            end
            7'b1100011: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = model_pc + imm_b;
                end
            end
            default: ;   // Unknown opcode retires as a no-op
        endcase
        if (exp_we && exp_rd != 5'd0) begin
            model_regs[exp_rd] = exp_data;
        end
        model_pc = next_pc;
    endfunction

    initial begin
        reset = 1'b1;
        br_f3 = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        place(u_type(20'h80000, 5'd1));                     // x1 = most negative
        place(i_type(12'hfff, 5'd0, 3'b000, 5'd2));         // x2 = -1
        place(i_type(12'h001, 5'd0, 3'b000, 5'd3));         // x3 = 1
        place(r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));     // SUB
        place(r_type(7'h20, 5'd3, 5'd1, 3'b101, 5'd5));     // SRA
        place(i_type(12'h41f, 5'd1, 3'b101, 5'd6));         // SRAI by 31
        place(i_type(12'h004, 5'd1, 3'b101, 5'd7));         // SRLI
        place(r_type(7'h00, 5'd3, 5'd1, 3'b010, 5'd8));     // SLT
        place(r_type(7'h00, 5'd3, 5'd1, 3'b011, 5'd9));     // SLTU
        place(i_type(12'hfff, 5'd3, 3'b010, 5'd10));        // SLTI
        place(i_type(12'hfff, 5'd3, 3'b011, 5'd11));        // SLTIU
        place(i_type(12'h07b, 5'd3, 3'b000, 5'd0));         // Write to x0
        place(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd12));    // x0 reads back zero
        place(32'h0000_0000);                               // Unknown opcode
        place(r_type(7'h20, 5'd3, 5'd0, 3'b000, 5'd13));    // 0 - 1
        place(i_type(12'h7ff, 5'd2, 3'b000, 5'd15));
        // Each branch with (x1,x3), (x3,x1), (x3,x3) hits taken and not taken
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                place(b_type(br_f3[3'(k)], (p == 0) ? 5'd1 : 5'd3,
                             (p == 1) ? 5'd1 : 5'd3, 13'd8));
                place(i_type(12'h001, 5'd12, 3'b000, 5'd12));   // Skipped when taken
            end
        end
        place(j_type(5'd14, 21'd8));                        // JAL over one word
        place(i_type(12'h7ff, 5'd0, 3'b000, 5'd13));
        while (fill < 64) begin
            place(random_instr());
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

    // Retirement checker
    always @(posedge clk) begin
        logic     exp_we;
        reg_idx_t exp_rd;
        word_t    exp_data, exp_pc;
        cycles++;
        if (reset) begin
            since_reset = 0;
            model_pc    = START_PC;
            for (int r = 0; r < 32; r++) begin
                model_regs[5'(r)] = '0;
            end
            if (retire || rd_we) begin
                $display("retire or rd_we active during reset");
                errors++;
            end
        end else begin
            since_reset++;
            if (retire) begin
                if (retires == 0 && since_reset != 4) begin
                    $display("first retire came %0d cycles after reset, not 4", since_reset);
                    errors++;
                end
                exp_pc = model_pc;
                iss_step(exp_we, exp_rd, exp_data);
                if (retire_pc !== exp_pc) begin
                    $display("MISMATCH retire_pc: expected %h, got %h", exp_pc, retire_pc);
                    errors++;
                end
                if (rd_we !== exp_we) begin
                    $display("MISMATCH rd_we at pc %h: expected %h, got %h", exp_pc, exp_we, rd_we);
                    errors++;
                end
                if (exp_we && rd_addr !== exp_rd) begin
                    $display("MISMATCH rd_addr at pc %h: expected %h, got %h",
                             exp_pc, exp_rd, rd_addr);
                    errors++;
                end
                if (exp_we && rd_data !== exp_data) begin
                    $display("MISMATCH rd_data at pc %h: expected %h, got %h",
                             exp_pc, exp_data, rd_data);
                    errors++;
                end
                checked += exp_we ? 4 : 2;
                retires++;
            end
        end
    end

    initial begin
        wait (retires >= NUM_RETIRES || cycles >= CYCLE_LIMIT);
        if (retires < NUM_RETIRES) begin
            $display("timeout: retire count not reached");
        end
        $display("checked %0d fields over %0d retires, %0d errors", checked, retires, errors);
        if (errors == 0 && retires >= NUM_RETIRES) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_imm_gen.sv
`default_nettype none

module rv_imm_gen
    import rv_pkg::*;
(
    input  word_t     instr,
    input  imm_kind_e imm_kind,
    output word_t     imm
);

    // Sign bit is always instr[31]
    always_comb begin
        case (imm_kind)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_U: imm = {instr[31:12], 12'b0};           // Low 12 bits zero
            IMM_B: begin
                // Scrambled branch offset, bit 0 implied
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            IMM_J: begin
                // Jump offset, 21 bits with implied bit 0
                imm = {{11{instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;                 // Data and address width

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;        // Architectural register index

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,   // R-type ALU
        OP_IMM    = 7'b0010011,   // I-type ALU
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // One state per cycle of an instruction
    typedef enum logic [1:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_WRITEBACK
    } state_e;

    typedef enum logic {SRC_A_RS1, SRC_A_PC} src_a_e;
    typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_e;
    typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_FLAG} wb_sel_e;   // Register write source
    typedef enum logic [1:0] {IMM_I, IMM_U, IMM_B, IMM_J} imm_kind_e;

    // Branch conditions in funct3
    localparam logic [2:0] BEQ  = 3'b000;
    localparam logic [2:0] BNE  = 3'b001;
    localparam logic [2:0] BLT  = 3'b100;
    localparam logic [2:0] BGE  = 3'b101;
    localparam logic [2:0] BLTU = 3'b110;
    localparam logic [2:0] BGEU = 3'b111;

endpackage

`default_nettype wire

//--- rv_regfile.sv
`default_nettype none

module rv_regfile
    import rv_pkg::*;
#(
    parameter int NUM_REGS = 32   // 32 for RV32I, 16 for an RV32E-sized file
) (
    input  logic     clk,
    input  reg_idx_t rs1_addr,
    input  reg_idx_t rs2_addr,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_idx_t rd_addr,
    input  word_t    rd_data
);

    localparam int IDX_W = $clog2(NUM_REGS);

    word_t regs [NUM_REGS];
    logic [IDX_W-1:0] rs1_idx, rs2_idx, rd_idx;   // Truncated indices

    assign rs1_idx = rs1_addr[IDX_W-1:0];
    assign rs2_idx = rs2_addr[IDX_W-1:0];
    assign rd_idx  = rd_addr[IDX_W-1:0];

    // Asynchronous reads, x0 forced to zero
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (we && rd_idx != '0) begin   // Writes to x0 dropped
            regs[rd_idx] <= rd_data;
        end
    end

endmodule

`default_nettype wire
